// File: hw/rvPkg.sv
`default_nettype none

package rvPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;

	typedef enum logic [6:0] {
		opOp     = 7'b0110011,
		opImm    = 7'b0010011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opBranch = 7'b1100011,
		opSystem = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt
	} aluOp_e;

	// same 32 bits, four decodings
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			regAddr_t rs2;
			regAddr_t rs1;
			logic [2:0] funct3;
			regAddr_t rd;
			logic [6:0] opcode;
		} rType;
		struct packed {
			logic [11:0] imm12;
			regAddr_t rs1;
			logic [2:0] funct3;
			regAddr_t rd;
			logic [6:0] opcode;
		} iType;
		struct packed {
			logic [6:0] immHi;
			regAddr_t rs2;
			regAddr_t rs1;
			logic [2:0] funct3;
			logic [4:0] immLo;
			logic [6:0] opcode;
		} sType;
		struct packed {
			logic imm12;
			logic [5:0] imm10to5;
			regAddr_t rs2;
			regAddr_t rs1;
			logic [2:0] funct3;
			logic [3:0] imm4to1;
			logic imm11;
			logic [6:0] opcode;
		} bType;
	} rvInstr_t;

endpackage

`default_nettype wire

// File: hw/ctrlIf.sv
`timescale 1ns/10ps
`default_nettype none

interface ctrlIf;
	import rvPkg::*;

	aluOp_e aluOp;
	logic aluSrcImm;
	logic memWrite;
	logic memToReg;
	logic regWrite;
	logic branch;
	// BNE when set, BEQ otherwise
	logic branchNe;
	word_t imm;

	modport decoder (
		output aluOp, aluSrcImm, memWrite, memToReg, regWrite, branch, branchNe, imm
	);

	modport datapath (
		input aluOp, aluSrcImm, memWrite, memToReg, regWrite, branch, branchNe, imm
	);

endinterface

`default_nettype wire

// File: hw/instrDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
	input rvPkg::rvInstr_t instr,
	ctrlIf.decoder ctrl,
	output logic isEbreak
);
	import rvPkg::*;

	word_t iImm;
	word_t sImm;
	word_t bImm;

	// only ADD/SLT/XOR/OR/AND slots, shifts and SLTU are not supported
	function automatic logic funct3Known(input logic [2:0] funct3);
		return funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
	endfunction

	function automatic aluOp_e funct3ToAluOp(input logic [2:0] funct3, input logic isSub);
		case (funct3)
			3'b000: return isSub ? aluSub : aluAdd;
			3'b010: return aluSlt;
			3'b100: return aluXor;
			3'b110: return aluOr;
			3'b111: return aluAnd;
			default: return aluAdd;
		endcase
	endfunction

	assign iImm = {{20{instr.iType.imm12[11]}}, instr.iType.imm12};
	assign sImm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
	assign bImm = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
		instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};

	always_comb begin
		ctrl.aluOp = aluAdd;
		ctrl.aluSrcImm = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.memToReg = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.branch = 1'b0;
		ctrl.branchNe = 1'b0;
		ctrl.imm = '0;
		isEbreak = 1'b0;
		case (instr.rType.opcode)
			opOp: begin
				ctrl.aluOp = funct3ToAluOp(instr.rType.funct3, instr.rType.funct7[5]);
				// funct7 must be zero, or SUB's pattern on the add slot
				ctrl.regWrite = funct3Known(instr.rType.funct3) &&
					(instr.rType.funct7 == 7'b0000000 ||
					(instr.rType.funct7 == 7'b0100000 && instr.rType.funct3 == 3'b000));
			end
			opImm: begin
				ctrl.aluOp = funct3ToAluOp(instr.iType.funct3, 1'b0);
				ctrl.aluSrcImm = 1'b1;
				ctrl.imm = iImm;
				ctrl.regWrite = funct3Known(instr.iType.funct3);
			end
			opLoad: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.imm = iImm;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = instr.iType.funct3 == 3'b010;
			end
			opStore: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.imm = sImm;
				ctrl.memWrite = instr.sType.funct3 == 3'b010;
			end
			opBranch: begin
				// compare by subtraction, zero flag decides
				ctrl.aluOp = aluSub;
				ctrl.imm = bImm;
				ctrl.branch = instr.bType.funct3[2:1] == 2'b00;
				ctrl.branchNe = instr.bType.funct3[0];
			end
			opSystem: begin
				isEbreak = instr.iType.imm12 == 12'h001 && instr.iType.rs1 == '0 &&
					instr.iType.funct3 == 3'b000 && instr.iType.rd == '0;
			end
			default: begin
				// unknown opcode, no enables
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input logic clk,
	input logic reset,
	input logic we,
	input rvPkg::regAddr_t waddr,
	input rvPkg::regAddr_t raddr1,
	input rvPkg::regAddr_t raddr2,
	input rvPkg::word_t wdata,
	output rvPkg::word_t rdata1,
	output rvPkg::word_t rdata2
);
	import rvPkg::*;

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
	input rvPkg::aluOp_e op,
	input rvPkg::word_t a,
	input rvPkg::word_t b,
	output rvPkg::word_t result,
	output logic zero
);
	import rvPkg::*;

	always_comb begin
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			// signed compare
			aluSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: result = '0;
		endcase
	end

	// branches read this after a subtract
	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hw/dataMem.sv
`timescale 1ns/10ps
`default_nettype none

module dataMem #(
	parameter int memWords = 256
) (
	input logic clk,
	input logic reset,
	input logic we,
	input rvPkg::word_t addr,
	input rvPkg::word_t wdata,
	output rvPkg::word_t rdata
);
	import rvPkg::*;

	localparam int idxW = (memWords > 1) ? $clog2(memWords) : 1;

	word_t mem [memWords];
	logic [idxW-1:0] wordIdx;

	// byte address to word slot, wrapping at the depth
	assign wordIdx = idxW'((addr >> 2) % memWords);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < memWords; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[wordIdx] <= wdata;
		end
	end

	assign rdata = mem[wordIdx];

endmodule

`default_nettype wire

// File: hw/pcUnit.sv
`timescale 1ns/10ps
`default_nettype none

module pcUnit #(
	parameter rvPkg::word_t resetPc = 32'h0
) (
	input logic clk,
	input logic reset,
	input logic advance,
	input logic takeBranch,
	input rvPkg::word_t offset,
	output rvPkg::word_t pc
);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetPc;
		end else if (advance) begin
			// branch target or next sequential word
			if (takeBranch) begin
				pc <= pc + offset;
			end else begin
				pc <= pc + 32'd4;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/coreTop.sv
`timescale 1ns/10ps
`default_nettype none

module coreTop #(
	parameter int memWords = 256,
	parameter rvPkg::word_t resetPc = 32'h0
) (
	input logic clk,
	input logic reset,
	input rvPkg::rvInstr_t instr,
	input logic instrValid,
	output rvPkg::word_t pc,
	output logic wbValid,
	output rvPkg::regAddr_t wbAddr,
	output rvPkg::word_t wbData,
	output logic halt
);
	import rvPkg::*;

	ctrlIf ctrl ();

	logic isEbreak;
	logic active;
	logic regWe;
	logic memWe;
	logic aluZero;
	logic takeBranch;
	word_t rdata1;
	word_t rdata2;
	word_t aluB;
	word_t aluResult;
	word_t memRdata;

	// a strobe only counts before halt
	assign active = instrValid && !halt;
	assign regWe = ctrl.regWrite && active;
	assign memWe = ctrl.memWrite && active;

	always_ff @(posedge clk) begin
		if (reset) begin
			halt <= 1'b0;
		end else if (active && isEbreak) begin
			halt <= 1'b1;
		end
	end

	instrDecoder instrDecoder_inst (
		.instr(instr),
		.ctrl(ctrl.decoder),
		.isEbreak(isEbreak)
	);

	regFile regFile_inst (
		.clk(clk),
		.reset(reset),
		.we(regWe),
		.waddr(instr.rType.rd),
		.raddr1(instr.rType.rs1),
		.raddr2(instr.rType.rs2),
		.wdata(wbData),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	assign aluB = ctrl.aluSrcImm ? ctrl.imm : rdata2;

	alu alu_inst (
		.op(ctrl.aluOp),
		.a(rdata1),
		.b(aluB),
		.result(aluResult),
		.zero(aluZero)
	);

	dataMem #(
		.memWords(memWords)
	) dataMem_inst (
		.clk(clk),
		.reset(reset),
		.we(memWe),
		.addr(aluResult),
		.wdata(rdata2),
		.rdata(memRdata)
	);

	// BEQ on zero, BNE on nonzero
	assign takeBranch = ctrl.branch && (ctrl.branchNe ? !aluZero : aluZero);

	pcUnit #(
		.resetPc(resetPc)
	) pcUnit_inst (
		.clk(clk),
		.reset(reset),
		.advance(active),
		.takeBranch(takeBranch),
		.offset(ctrl.imm),
		.pc(pc)
	);

	// write-back trace
	assign wbValid = regWe;
	assign wbAddr = instr.rType.rd;
	assign wbData = ctrl.memToReg ? memRdata : aluResult;

endmodule

`default_nettype wire

// File: tb/coreTop_props.sv
`timescale 1ns/10ps
`default_nettype none

module coreTopProps #(
	parameter rvPkg::word_t resetPc = 32'h0
) (
	input logic clk,
	input logic reset,
	input logic instrValid,
	input rvPkg::word_t pc,
	input logic wbValid,
	input logic halt
);

	pcAfterReset: assert property (@(posedge clk) reset |=> pc == resetPc)
		else $error("pc differs from its reset value after reset");

	pcHoldsWhenIdle: assert property (@(posedge clk) disable iff (reset)
		!instrValid |=> $stable(pc))
		else $error("pc moved without a strobe");

	haltSticky: assert property (@(posedge clk) disable iff (reset) halt |=> halt)
		else $error("halt dropped before reset");

	// write-back ops never branch, so the strobe moves pc to the next word
	wbAdvancesPc: assert property (@(posedge clk) disable iff (reset)
		wbValid |-> instrValid ##1 pc == $past(pc) + 32'd4)
		else $error("write-back without a strobe that advances pc by 4");

endmodule

bind coreTop coreTopProps #(.resetPc(resetPc)) coreTopProps_inst (
	.clk(clk),
	.reset(reset),
	.instrValid(instrValid),
	.pc(pc),
	.wbValid(wbValid),
	.halt(halt)
);

`default_nettype wire

// File: tb/coreTb.sv
`timescale 1ns/10ps
`default_nettype none

module coreTb;
	import rvPkg::*;

	localparam int memWords = 256;
	localparam word_t resetPc = 32'h0;
	// upper bound on strobes and reset cycles over all tests
	localparam int strobeBudget = 300;
	localparam int timeoutNs = strobeBudget * 8 + 200;

	logic clk;
	logic reset;
	rvInstr_t instr;
	logic instrValid;
	word_t pc;
	logic wbValid;
	regAddr_t wbAddr;
	word_t wbData;
	logic halt;

	// reference model state
	word_t refRegs [32];
	word_t refMem [memWords];
	word_t refPc;
	logic refHalt;
	logic [31:0] rngState;

	coreTop #(
		.memWords(memWords),
		.resetPc(resetPc)
	) coreTop_inst (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.instrValid(instrValid),
		.pc(pc),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.halt(halt)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	initial begin
		#(timeoutNs);
		$display("Timeout: the core did not finish the tests in time");
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic word_t sext12(input logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	function automatic word_t sext13(input logic [12:0] imm);
		return {{19{imm[12]}}, imm};
	endfunction

	// RV32I semantics of the supported ALU operations
	function automatic word_t aluRef(input logic [2:0] f3, input logic isSub,
		input word_t a, input word_t b);
		case (f3)
			3'b000: return isSub ? a - b : a + b;
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic int memIndex(input word_t addr);
		return int'((addr >> 2) % memWords);
	endfunction

	function automatic rvInstr_t encR(input logic isSub, input regAddr_t rs2,
		input regAddr_t rs1, input logic [2:0] f3, input regAddr_t rd);
		return {isSub ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, opOp};
	endfunction

	function automatic rvInstr_t encI(input logic [11:0] imm, input regAddr_t rs1,
		input logic [2:0] f3, input regAddr_t rd, input opcode_e op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rvInstr_t encS(input logic [11:0] imm, input regAddr_t rs2,
		input regAddr_t rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
	endfunction

	function automatic rvInstr_t encB(input logic [12:0] off, input regAddr_t rs2,
		input regAddr_t rs1, input logic ne);
		return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], opBranch};
	endfunction

	task automatic stopOnMismatch(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		$display("FAIL %s expected %h got %h", name, expVal, actVal);
		$display("Checks failed");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic checkWord(input string name, input word_t act, input word_t expVal);
		if (act !== expVal) begin
			stopOnMismatch(name, expVal, act);
		end
	endtask

	task automatic checkAddr(input string name, input regAddr_t act, input regAddr_t expVal);
		if (act !== expVal) begin
			stopOnMismatch(name, 32'(expVal), 32'(act));
		end
	endtask

	task automatic checkBit(input string name, input logic act, input logic expVal);
		if (act !== expVal) begin
			stopOnMismatch(name, 32'(expVal), 32'(act));
		end
	endtask

	task automatic applyReset();
		reset = 1'b1;
		instrValid = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		foreach (refRegs[i]) begin
			refRegs[i] = '0;
		end
		foreach (refMem[i]) begin
			refMem[i] = '0;
		end
		refPc = resetPc;
		refHalt = 1'b0;
		checkWord("pc", pc, resetPc);
		checkBit("halt", halt, 1'b0);
		checkBit("wbValid", wbValid, 1'b0);
	endtask

	// one strobe at posedge+1, trace sampled late in the cycle
	task automatic strobe(input rvInstr_t word, input logic expValid, input regAddr_t expAddr,
		input word_t expData, input word_t expPc, input logic isEbreak);
		instr = word;
		instrValid = 1'b1;
		#6;
		checkBit("wbValid", wbValid, expValid && !refHalt);
		if (expValid && !refHalt) begin
			checkAddr("wbAddr", wbAddr, expAddr);
			checkWord("wbData", wbData, expData);
		end
		@(posedge clk);
		#1;
		instrValid = 1'b0;
		if (!refHalt) begin
			if (expValid && expAddr != '0) begin
				refRegs[expAddr] = expData;
			end
			refPc = expPc;
			refHalt = isEbreak;
		end
		checkWord("pc", pc, refPc);
		checkBit("halt", halt, refHalt);
	endtask

	task automatic idleCycles(input int n);
		repeat (n) begin
			// a valid-looking ADDI that must be ignored
			instr = encI(12'h7ff, 5'd0, 3'b000, 5'd1, opImm);
			#6;
			checkBit("wbValid", wbValid, 1'b0);
			@(posedge clk);
			#1;
			checkWord("pc", pc, refPc);
			checkBit("halt", halt, refHalt);
		end
	endtask

	task automatic doR(input logic [2:0] f3, input logic isSub, input regAddr_t rd,
		input regAddr_t rs1, input regAddr_t rs2);
		word_t expData;
		expData = aluRef(f3, isSub, refRegs[rs1], refRegs[rs2]);
		strobe(encR(isSub, rs2, rs1, f3, rd), 1'b1, rd, expData, refPc + 4, 1'b0);
	endtask

	task automatic doI(input logic [2:0] f3, input regAddr_t rd, input regAddr_t rs1,
		input logic [11:0] imm);
		word_t expData;
		expData = aluRef(f3, 1'b0, refRegs[rs1], sext12(imm));
		strobe(encI(imm, rs1, f3, rd, opImm), 1'b1, rd, expData, refPc + 4, 1'b0);
	endtask

	task automatic doSw(input regAddr_t rs2, input regAddr_t rs1, input logic [11:0] imm);
		if (!refHalt) begin
			refMem[memIndex(refRegs[rs1] + sext12(imm))] = refRegs[rs2];
		end
		strobe(encS(imm, rs2, rs1), 1'b0, '0, '0, refPc + 4, 1'b0);
	endtask

	task automatic doLw(input regAddr_t rd, input regAddr_t rs1, input logic [11:0] imm);
		word_t expData;
		expData = refMem[memIndex(refRegs[rs1] + sext12(imm))];
		strobe(encI(imm, rs1, 3'b010, rd, opLoad), 1'b1, rd, expData, refPc + 4, 1'b0);
	endtask

	task automatic doBranch(input logic ne, input regAddr_t rs1, input regAddr_t rs2,
		input logic [12:0] off);
		logic taken;
		taken = ne ? (refRegs[rs1] != refRegs[rs2]) : (refRegs[rs1] == refRegs[rs2]);
		strobe(encB(off, rs2, rs1, ne), 1'b0, '0, '0,
			taken ? refPc + sext13(off) : refPc + 4, 1'b0);
	endtask

	// 11 + 11 + 10 bit chunks, shifted up by doubling
	task automatic loadValue(input regAddr_t rd, input word_t value);
		doI(3'b000, rd, 5'd0, {1'b0, value[31:21]});
		repeat (11) doR(3'b000, 1'b0, rd, rd, rd);
		doI(3'b000, rd, rd, {1'b0, value[20:10]});
		repeat (10) doR(3'b000, 1'b0, rd, rd, rd);
		doI(3'b000, rd, rd, {2'b00, value[9:0]});
	endtask

	task automatic testRegOps();
		repeat (2) begin
			rngState = xorshift32(rngState);
			loadValue(5'd1, rngState);
			rngState = xorshift32(rngState);
			loadValue(5'd2, rngState);
			doR(3'b000, 1'b0, 5'd3, 5'd1, 5'd2);
			doR(3'b000, 1'b1, 5'd4, 5'd1, 5'd2);
			doR(3'b111, 1'b0, 5'd5, 5'd1, 5'd2);
			doR(3'b110, 1'b0, 5'd6, 5'd1, 5'd2);
			doR(3'b100, 1'b0, 5'd7, 5'd1, 5'd2);
			doR(3'b010, 1'b0, 5'd8, 5'd1, 5'd2);
			doR(3'b010, 1'b0, 5'd9, 5'd2, 5'd1);
		end
	endtask

	task automatic testImmOps();
		logic [11:0] imms [4] = '{12'h800, 12'hf85, 12'h7ff, 12'h155};
		logic [2:0] f3s [5] = '{3'b000, 3'b111, 3'b110, 3'b100, 3'b010};
		foreach (imms[i]) begin
			foreach (f3s[j]) begin
				doI(f3s[j], 5'd10, 5'd1, imms[i]);
			end
		end
		doI(3'b000, 5'd11, 5'd0, 12'h800);
	endtask

	task automatic testLoadStore();
		rngState = xorshift32(rngState);
		loadValue(5'd12, rngState);
		doI(3'b000, 5'd13, 5'd0, 12'd8);
		doSw(5'd12, 5'd13, 12'd0);
		doLw(5'd14, 5'd13, 12'd0);
		// byte 1032 is past the end, lands on word 2
		doI(3'b000, 5'd15, 5'd0, 12'h408);
		doLw(5'd16, 5'd15, 12'd0);
		rngState = xorshift32(rngState);
		loadValue(5'd17, rngState);
		doSw(5'd17, 5'd15, 12'h7f0);
		doLw(5'd18, 5'd0, 12'h7f8);
		doSw(5'd12, 5'd13, 12'hffc);
		doLw(5'd19, 5'd0, 12'd4);
		doLw(5'd20, 5'd13, 12'd12);
	endtask

	task automatic testBranches();
		doBranch(1'b0, 5'd1, 5'd1, 13'd16);
		doBranch(1'b0, 5'd1, 5'd2, 13'd16);
		doBranch(1'b1, 5'd1, 5'd2, 13'h1fe0);
		doBranch(1'b1, 5'd1, 5'd1, 13'h1fe0);
		doBranch(1'b0, 5'd3, 5'd3, 13'h1ff8);
		doBranch(1'b1, 5'd2, 5'd1, 13'h0ff0);
	endtask

	task automatic testZeroRegAndIdle();
		doI(3'b000, 5'd0, 5'd0, 12'h005);
		doR(3'b000, 1'b0, 5'd0, 5'd1, 5'd2);
		doR(3'b000, 1'b0, 5'd21, 5'd0, 5'd1);
		doR(3'b110, 1'b0, 5'd22, 5'd0, 5'd0);
		idleCycles(4);
		doR(3'b000, 1'b0, 5'd23, 5'd1, 5'd0);
	endtask

	task automatic testHalt();
		strobe(encI(12'h001, 5'd0, 3'b000, 5'd0, opSystem), 1'b0, '0, '0, refPc + 4, 1'b1);
		doSw(5'd1, 5'd13, 12'd0);
		doI(3'b000, 5'd24, 5'd0, 12'h123);
		doBranch(1'b0, 5'd1, 5'd1, 13'd16);
		idleCycles(2);
		applyReset();
		doI(3'b000, 5'd25, 5'd0, 12'h042);
	endtask

	initial begin
		instr = '0;
		instrValid = 1'b0;
		reset = 1'b1;
		rngState = 32'h3890;
		applyReset();
		testRegOps();
		testImmOps();
		testLoadStore();
		testBranches();
		testZeroRegAndIdle();
		testHalt();
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
hw/rvPkg.sv
hw/ctrlIf.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/alu.sv
hw/dataMem.sv
hw/pcUnit.sv
hw/coreTop.sv
tb/coreTop_props.sv
tb/coreTb.sv
